//--- source/cache_pkg.sv
// shared widths, bus types and controller states for the cache
// every cache module refers to these by scoped name
// both the cpu side and the memory side are wishbone classic
`default_nettype none

package cache_pkg;

    // word address and data word
    parameter int ADDR_W = 16;
    parameter int WORD_W = 32;

    // geometry of a set
    parameter int NUM_WAYS = 4;
    parameter int WORDS_PER_BLOCK = 4;
    parameter int OFFSET_W = 2;

    // one age per way, 0 is most recent
    parameter int AGE_W = 2;

    typedef logic [1:0] way_t;

    // master side of a wishbone classic bus
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [WORD_W-1:0] dat;
    } wb_req_t;

    // slave side, ack is a single cycle per transfer
    typedef struct packed {
        logic              ack;
        logic [WORD_W-1:0] dat;
    } wb_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        RESPOND
    } cache_state_e;

endpackage

`default_nettype wire

//--- source/beat_counter.sv
// beat counter for block transfers on the memory bus
// step on each memory ack, clear before a new block
`timescale 1ns/10ps
`default_nettype none

module beat_counter (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          clear,
    input  wire logic                          step,
    output logic [cache_pkg::OFFSET_W-1:0]     beat,
    output logic                               last
);

    typedef logic [cache_pkg::OFFSET_W-1:0] beat_t;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            beat <= '0;
        else if (clear)
            beat <= '0;
        else if (step)
            beat <= beat + 1'b1;
    end

    // final word of the block
    assign last = (beat == beat_t'(cache_pkg::WORDS_PER_BLOCK - 1));

    // the controller must restart the count when the last beat is acked
    a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        step && last |-> clear);

endmodule

`default_nettype wire

//--- source/tag_store.sv
// valid, dirty, tag and LRU age arrays of the cache
// hit and victim come combinationally from addr
// fill, touch and mark_dirty update the way on sel_way at the clock edge
`timescale 1ns/10ps
`default_nettype none

module tag_store #(
    parameter int NUM_SETS = 8
) (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic [cache_pkg::ADDR_W-1:0]    addr,
    input  wire cache_pkg::way_t                 sel_way,
    input  wire logic                           fill,
    input  wire logic                           touch,
    input  wire logic                           mark_dirty,
    output logic                                hit,
    output cache_pkg::way_t                     hit_way,
    output cache_pkg::way_t                     victim_way,
    output logic                                victim_dirty,
    output logic [cache_pkg::ADDR_W-cache_pkg::OFFSET_W-$clog2(NUM_SETS)-1:0] victim_tag
);

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::OFFSET_W - IDX_W;

    typedef logic [cache_pkg::AGE_W-1:0] age_t;

    logic [cache_pkg::NUM_WAYS-1:0] valid_q [NUM_SETS];
    logic [cache_pkg::NUM_WAYS-1:0] dirty_q [NUM_SETS];
    age_t                           age_q   [NUM_SETS][cache_pkg::NUM_WAYS];
    logic [TAG_W-1:0]               tag_q   [NUM_SETS][cache_pkg::NUM_WAYS];

    logic [IDX_W-1:0]               index;
    logic [TAG_W-1:0]               tag;
    logic [cache_pkg::NUM_WAYS-1:0] match;

    assign index = addr[cache_pkg::OFFSET_W +: IDX_W];
    assign tag   = addr[cache_pkg::ADDR_W-1 -: TAG_W];

    // parallel compare of all ways
    always_comb
    begin
        match   = '0;
        hit_way = '0;
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++)
        begin
            match[w] = valid_q[index][w] && (tag_q[index][w] == tag);
            if (match[w])
                hit_way = cache_pkg::way_t'(w);
        end
    end

    assign hit = |match;

    always_comb
    begin
        victim_way = '0;
        // oldest way of a full set
        for (int w = cache_pkg::NUM_WAYS - 1; w >= 0; w--)
        begin
            if (age_q[index][w] == age_t'(cache_pkg::NUM_WAYS - 1))
                victim_way = cache_pkg::way_t'(w);
        end
        // lowest invalid way takes priority
        for (int w = cache_pkg::NUM_WAYS - 1; w >= 0; w--)
        begin
            if (!valid_q[index][w])
                victim_way = cache_pkg::way_t'(w);
        end
    end

    assign victim_dirty = valid_q[index][victim_way] && dirty_q[index][victim_way];
    assign victim_tag   = tag_q[index][victim_way];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int s = 0; s < NUM_SETS; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                // ages start as a permutation, way 3 oldest
                for (int w = 0; w < cache_pkg::NUM_WAYS; w++)
                    age_q[s][w] <= age_t'(w);
            end
        end
        else
        begin
            // fill wins over a refill beat's mark_dirty
            if (fill)
            begin
                valid_q[index][sel_way] <= 1'b1;
                dirty_q[index][sel_way] <= 1'b0;
            end
            else if (mark_dirty)
                dirty_q[index][sel_way] <= 1'b1;

            if (touch)
            begin
                for (int w = 0; w < cache_pkg::NUM_WAYS; w++)
                begin
                    if (cache_pkg::way_t'(w) == sel_way)
                        age_q[index][w] <= '0;
                    else if (age_q[index][w] < age_q[index][sel_way])
                        age_q[index][w] <= age_q[index][w] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill)
            tag_q[index][sel_way] <= tag;
    end

    // a tag lives in one way of its set only
    a_one_hit: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(match));

endmodule

`default_nettype wire

//--- source/data_store.sv
// block data of all ways and sets, one word per access
// read is combinational, write lands at the clock edge
// one port shared by hit reads, write-back, refill and cpu writes
`timescale 1ns/10ps
`default_nettype none

module data_store #(
    parameter int NUM_SETS = 8
) (
    input  wire logic                              clk,
    input  wire logic [$clog2(NUM_SETS)-1:0]       index,
    input  wire logic [cache_pkg::OFFSET_W-1:0]    offset,
    input  wire cache_pkg::way_t                    way,
    input  wire logic                              we,
    input  wire logic [cache_pkg::WORD_W-1:0]      wdata,
    output logic [cache_pkg::WORD_W-1:0]           rdata
);

    // way, set, word within block
    logic [cache_pkg::WORD_W-1:0] mem_q
        [cache_pkg::NUM_WAYS][NUM_SETS][cache_pkg::WORDS_PER_BLOCK];

    always_ff @(posedge clk)
    begin
        if (we)
            mem_q[way][index][offset] <= wdata;
    end

    // old word is visible until the edge
    assign rdata = mem_q[way][index][offset];

endmodule

`default_nettype wire

//--- source/cache_ctrl.sv
// cache controller FSM
// latches one cpu request, looks it up, writes back a dirty victim,
// refills the block over the memory bus and then acks the cpu
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl #(
    parameter int NUM_SETS = 8
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire cache_pkg::wb_req_t                    cpu_req,
    output cache_pkg::wb_rsp_t                        cpu_rsp,
    output cache_pkg::wb_req_t                        mem_req,
    input  wire cache_pkg::wb_rsp_t                    mem_rsp,
    input  wire logic                                 hit,
    input  wire cache_pkg::way_t                       hit_way,
    input  wire cache_pkg::way_t                       victim_way,
    input  wire logic                                 victim_dirty,
    input  wire logic [cache_pkg::ADDR_W-cache_pkg::OFFSET_W-$clog2(NUM_SETS)-1:0] victim_tag,
    input  wire logic [cache_pkg::WORD_W-1:0]          rd_word,
    input  wire logic [cache_pkg::OFFSET_W-1:0]        beat,
    input  wire logic                                 beat_last,
    output logic                                      beat_clear,
    output logic                                      beat_step,
    output logic [cache_pkg::ADDR_W-1:0]              req_addr,
    output cache_pkg::way_t                           sel_way,
    output logic                                      tag_fill,
    output logic                                      tag_touch,
    output logic                                      data_we,
    output logic [cache_pkg::WORD_W-1:0]              data_wdata,
    output logic [cache_pkg::OFFSET_W-1:0]            data_offset
);

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::OFFSET_W - IDX_W;

    cache_pkg::cache_state_e      state;
    cache_pkg::cache_state_e      state_nxt;
    logic                         req_we;
    logic [cache_pkg::WORD_W-1:0] req_dat;
    logic [TAG_W-1:0]             wb_tag;
    logic                         gap;
    logic                         mem_busy;
    logic                         mem_done;

    assign mem_busy = (state == cache_pkg::WRITEBACK) || (state == cache_pkg::REFILL);
    assign mem_done = mem_busy && mem_rsp.ack && beat_last;

    always_comb
    begin
        state_nxt = state;
        case (state)
            cache_pkg::IDLE:
                if (cpu_req.cyc && cpu_req.stb)
                    state_nxt = cache_pkg::LOOKUP;
            cache_pkg::LOOKUP:
                if (hit)
                    state_nxt = cache_pkg::RESPOND;
                else if (victim_dirty)
                    state_nxt = cache_pkg::WRITEBACK;
                else
                    state_nxt = cache_pkg::REFILL;
            cache_pkg::WRITEBACK:
                if (mem_done)
                    state_nxt = cache_pkg::REFILL;
            cache_pkg::REFILL:
                if (mem_done)
                    state_nxt = cache_pkg::RESPOND;
            default:
                state_nxt = cache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= cache_pkg::IDLE;
            gap   <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            // stb rests one cycle after every memory ack
            gap   <= mem_busy && mem_rsp.ack;
        end
    end

    // request fields stay put until the cpu sees ack
    always_ff @(posedge clk)
    begin
        if (state == cache_pkg::IDLE)
        begin
            req_addr <= cpu_req.adr;
            req_we   <= cpu_req.we;
            req_dat  <= cpu_req.dat;
        end
        if (state == cache_pkg::LOOKUP)
        begin
            sel_way <= hit ? hit_way : victim_way;
            wb_tag  <= victim_tag;
        end
    end

    // memory side, one single cycle per beat
    always_comb
    begin
        mem_req.cyc = mem_busy;
        mem_req.stb = mem_busy && !gap;
        mem_req.we  = (state == cache_pkg::WRITEBACK);
        mem_req.dat = rd_word;
        if (state == cache_pkg::WRITEBACK)
            mem_req.adr = {wb_tag, req_addr[cache_pkg::OFFSET_W +: IDX_W], beat};
        else
            mem_req.adr = {req_addr[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W], beat};
    end

    always_comb
    begin
        cpu_rsp.ack = (state == cache_pkg::RESPOND);
        cpu_rsp.dat = rd_word;
    end

    // beat count restarts for lookup and after each finished block
    assign beat_clear  = (state == cache_pkg::LOOKUP) || mem_done;
    assign beat_step   = mem_busy && mem_rsp.ack;

    assign tag_fill    = (state == cache_pkg::REFILL) && mem_done;
    assign tag_touch   = (state == cache_pkg::RESPOND);
    // refill beats land in the victim way, cpu writes at the end of RESPOND
    assign data_we     = ((state == cache_pkg::REFILL) && mem_rsp.ack) ||
                         ((state == cache_pkg::RESPOND) && req_we);
    assign data_wdata  = (state == cache_pkg::REFILL) ? mem_rsp.dat : req_dat;
    assign data_offset = mem_busy ? beat : req_addr[cache_pkg::OFFSET_W-1:0];

    // single-cycle ack, only from RESPOND
    a_ack_respond: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_rsp.ack |-> (state == cache_pkg::RESPOND) ##1 !cpu_rsp.ack);

    a_stb_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.stb |-> mem_req.cyc);

    // held beat keeps its address until memory acks it
    a_stb_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.stb && !mem_rsp.ack |=> mem_req.stb && $stable(mem_req.adr));

    a_we_writeback: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.we |-> (state == cache_pkg::WRITEBACK) && !cpu_rsp.ack);

endmodule

`default_nettype wire

//--- source/cache_top.sv
// four-way write-back, write-allocate cache with LRU replacement
// cpu_req/cpu_rsp face the processor, mem_req/mem_rsp face main memory
// NUM_SETS sets the number of sets and must be a power of two
`timescale 1ns/10ps
`default_nettype none

module cache_top #(
    parameter int NUM_SETS = 8
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire cache_pkg::wb_req_t cpu_req,
    output cache_pkg::wb_rsp_t     cpu_rsp,
    output cache_pkg::wb_req_t     mem_req,
    input  wire cache_pkg::wb_rsp_t mem_rsp
);

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = cache_pkg::ADDR_W - cache_pkg::OFFSET_W - IDX_W;

    // lookup results
    logic                            hit;
    cache_pkg::way_t                 hit_way;
    cache_pkg::way_t                 victim_way;
    logic                            victim_dirty;
    logic [TAG_W-1:0]                victim_tag;

    // block transfer beats
    logic [cache_pkg::OFFSET_W-1:0]  beat;
    logic                            beat_last;
    logic                            beat_clear;
    logic                            beat_step;

    // controller to the stores
    logic [cache_pkg::ADDR_W-1:0]    req_addr;
    cache_pkg::way_t                 sel_way;
    logic                            tag_fill;
    logic                            tag_touch;
    logic                            data_we;
    logic [cache_pkg::WORD_W-1:0]    data_wdata;
    logic [cache_pkg::OFFSET_W-1:0]  data_offset;
    logic [cache_pkg::WORD_W-1:0]    rd_word;

    cache_ctrl #(
        .NUM_SETS (NUM_SETS)
    ) i_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_req      (cpu_req),
        .cpu_rsp      (cpu_rsp),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .rd_word      (rd_word),
        .beat         (beat),
        .beat_last    (beat_last),
        .beat_clear   (beat_clear),
        .beat_step    (beat_step),
        .req_addr     (req_addr),
        .sel_way      (sel_way),
        .tag_fill     (tag_fill),
        .tag_touch    (tag_touch),
        .data_we      (data_we),
        .data_wdata   (data_wdata),
        .data_offset  (data_offset)
    );

    beat_counter i_beat (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (beat_clear),
        .step  (beat_step),
        .beat  (beat),
        .last  (beat_last)
    );

    // every data write marks the way dirty, a refill fill clears it again
    tag_store #(
        .NUM_SETS (NUM_SETS)
    ) i_tags (
        .clk          (clk),
        .rst_n        (rst_n),
        .addr         (req_addr),
        .sel_way      (sel_way),
        .fill         (tag_fill),
        .touch        (tag_touch),
        .mark_dirty   (data_we),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    data_store #(
        .NUM_SETS (NUM_SETS)
    ) i_data (
        .clk    (clk),
        .index  (req_addr[cache_pkg::OFFSET_W +: IDX_W]),
        .offset (data_offset),
        .way    (sel_way),
        .we     (data_we),
        .wdata  (data_wdata),
        .rdata  (rd_word)
    );

endmodule

`default_nettype wire

//--- test/tb_cache_top.sv
// testbench for the four-way write-back cache
// requests and expected results come from test/cache_patterns.txt
// a behavioral memory answers the memory bus after random wait cycles
// run through the Makefile, exit status gives pass or fail
`timescale 1ns/10ps
`default_nettype none

module tb_cache_top;

    // one line of the pattern file
    typedef struct packed {
        logic [7:0]  op;
        logic [15:0] adr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic        hit;
        logic        wb;
        logic [15:0] wb_adr;
    } pattern_t;

    logic               clk = 1'b0;
    logic               rst_n;
    cache_pkg::wb_req_t cpu_req;
    cache_pkg::wb_rsp_t cpu_rsp;
    cache_pkg::wb_req_t mem_req;
    cache_pkg::wb_rsp_t mem_rsp;

    pattern_t    patterns[$];
    logic [31:0] mem_words [0:65535];
    logic [31:0] cpu_words [logic [15:0]];
    logic [15:0] wr_adr_q[$];
    logic [31:0] wr_dat_q[$];
    logic [31:0] lfsr = 32'h3561;
    int          mem_acks = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    cache_top #(
        .NUM_SETS (8)
    ) i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    always #10 clk = ~clk;

    // fibonacci lfsr, taps 32 22 2 1, new bit enters at bit 0
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] initial_word(input logic [15:0] adr);
        return {16'h0000, adr} ^ 32'hA5A50000;
    endfunction

    // memory content as the cpu sees it
    function automatic logic [31:0] memory_value(input logic [15:0] adr);
        if (cpu_words.exists(adr))
            return cpu_words[adr];
        return initial_word(adr);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run stopped");
    endtask

    task automatic expect_equal(input string test_name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("mismatch %s expected %h actual %h", test_name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "check failed");
        end
    endtask

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [15:0] adr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic        hit;
        logic        wb;
        logic [15:0] wb_adr;
        fd = $fopen("test/cache_patterns.txt", "r");
        if (fd == 0)
            abort_run("cannot open the pattern file test/cache_patterns.txt");
        else
        begin
            // comment and blank lines do not parse to seven fields
            while ($fgets(line, fd) != 0)
            begin
                n = $sscanf(line, "%c %h %h %h %h %h %h", op, adr, wdata, rdata, hit, wb,
                            wb_adr);
                if (n == 7 && (op == "r" || op == "w"))
                    patterns.push_back({op, adr, wdata, rdata, hit, wb, wb_adr});
            end
            $fclose(fd);
        end
    endtask

    task automatic check_idle_outputs(input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            @(negedge clk);
            expect_equal("reset cpu ack", 32'd0, 32'(cpu_rsp.ack));
            expect_equal("reset mem cyc", 32'd0, 32'(mem_req.cyc));
            expect_equal("reset mem stb", 32'd0, 32'(mem_req.stb));
        end
    endtask

    // one cpu cycle, held until ack
    task automatic run_request(input int n, input pattern_t p);
        int    cycles;
        int    acks_before;
        string name;
        name = $sformatf("line %0d %c %h", n, p.op, p.adr);
        acks_before = mem_acks;
        wr_adr_q.delete();
        wr_dat_q.delete();
        @(posedge clk);
        cpu_req.cyc <= 1'b1;
        cpu_req.stb <= 1'b1;
        cpu_req.we  <= (p.op == "w");
        cpu_req.adr <= p.adr;
        cpu_req.dat <= p.wdata;
        cycles = 0;
        @(negedge clk);
        while (!cpu_rsp.ack)
        begin
            cycles++;
            @(negedge clk);
        end
        if (p.op == "r")
            expect_equal({name, " read data"}, p.rdata, cpu_rsp.dat);
        // a hit stays off the memory bus
        if (p.hit)
        begin
            expect_equal({name, " hit latency"}, 32'd2, 32'(cycles));
            expect_equal({name, " memory cycles on hit"}, 32'd0, 32'(mem_acks - acks_before));
        end
        else
            expect_equal({name, " memory cycles on miss"}, p.wb ? 32'd8 : 32'd4,
                         32'(mem_acks - acks_before));
        // evicted block leaves in beat order
        expect_equal({name, " write-back beats"}, p.wb ? 32'd4 : 32'd0, 32'(wr_adr_q.size()));
        foreach (wr_adr_q[i])
        begin
            expect_equal({name, " write-back address"}, 32'(p.wb_adr + 16'(i)),
                         32'(wr_adr_q[i]));
            expect_equal({name, " write-back data"}, memory_value(wr_adr_q[i]), wr_dat_q[i]);
        end
        if (p.op == "w")
            cpu_words[p.adr] = p.wdata;
        @(posedge clk);
        cpu_req.cyc <= 1'b0;
        cpu_req.stb <= 1'b0;
        cpu_req.we  <= 1'b0;
    endtask

    initial
    begin
        for (int a = 0; a < 65536; a++)
            mem_words[a] = initial_word(16'(a));
    end

    // memory model, 0 to 3 wait cycles before each ack
    always
    begin
        logic [15:0] adr;
        logic        we;
        logic [31:0] dat;
        logic [1:0]  wait_cycles;
        @(negedge clk);
        if (rst_n && mem_req.cyc && mem_req.stb)
        begin
            adr = mem_req.adr;
            we  = mem_req.we;
            dat = mem_req.dat;
            lfsr = lfsr_step(lfsr);
            wait_cycles[0] = lfsr[0];
            lfsr = lfsr_step(lfsr);
            wait_cycles[1] = lfsr[0];
            repeat (wait_cycles) @(posedge clk);
            @(posedge clk);
            mem_rsp.ack <= 1'b1;
            mem_rsp.dat <= we ? 32'h0 : mem_words[adr];
            if (we)
            begin
                mem_words[adr] = dat;
                wr_adr_q.push_back(adr);
                wr_dat_q.push_back(dat);
            end
            mem_acks++;
            @(posedge clk);
            mem_rsp.ack <= 1'b0;
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit)
            abort_run($sformatf("timeout, no result after %0d cycles", cycle_count));
    end

    initial
    begin
        cpu_req = '0;
        mem_rsp = '0;
        rst_n   = 1'b0;
        load_patterns();
        if (patterns.size() == 0)
            abort_run("the pattern file holds no requests");
        cycle_limit = 40 * patterns.size() + 100;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        check_idle_outputs(4);
        foreach (patterns[i])
            run_request(i + 1, patterns[i]);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- cache_top.f
source/cache_pkg.sv
source/beat_counter.sv
source/tag_store.sv
source/data_store.sv
source/cache_ctrl.sv
source/cache_top.sv
test/tb_cache_top.sv

//--- Makefile
# Verilator build and run of the cache testbench
# the run exits with a failing status when the testbench reports failure

TOP := tb_cache_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f cache_top.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

//--- test/cache_patterns.txt
# op addr wdata expected_rdata hit wb wb_addr, all hex
# hit 1 means no memory cycle, wb 1 means the block at wb_addr is written back
r 0010 00000000 a5a50010 0 0 0000
r 0011 00000000 a5a50011 1 0 0000
w 0013 deadbeef 00000000 1 0 0000
r 0013 00000000 deadbeef 1 0 0000
w 0104 12345678 00000000 0 0 0000
r 0104 00000000 12345678 1 0 0000
w 0002 cafef00d 00000000 0 0 0000
r 0020 00000000 a5a50020 0 0 0000
r 0040 00000000 a5a50040 0 0 0000
r 0060 00000000 a5a50060 0 0 0000
r 0080 00000000 a5a50080 0 1 0000
r 0021 00000000 a5a50021 1 0 0000
r 0002 00000000 cafef00d 0 0 0000
w 0061 11112222 00000000 1 0 0000
r 00a0 00000000 a5a500a0 0 0 0000
r 00c0 00000000 a5a500c0 0 0 0000
r 00e0 00000000 a5a500e0 0 0 0000
r 0100 00000000 a5a50100 0 1 0060
r 0061 00000000 11112222 0 0 0000
